// File: Makefile
TOP := tb_aurora_tx_top

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

obj_dir/V$(TOP): aurora_tx_top.f src/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -j 0 -f aurora_tx_top.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f aurora_tx_top.f --top-module aurora_tx_top

clean:
	rm -rf obj_dir sim.log

// File: aurora_tx_top.f
+incdir+test
src/aurora_link_pkg.sv
src/packet_format_pkg.sv
src/packet_if.sv
src/packet_fetch.sv
src/beat_serializer.sv
src/aurora_tx_top.sv
test/tb_aurora_tx_top.sv

// File: src/aurora_link_pkg.sv
package aurora_link_pkg;

    //////////////////////////////////////////////////
    // Lane geometry of the single-lane link
    //////////////////////////////////////////////////

    // One Aurora lane moves four bytes per beat
    parameter int unsigned LANE_BYTES = 4;
    parameter int unsigned LANE_BITS  = 8 * LANE_BYTES;   // Width of one stream beat

    // A byte count becomes a lane word count after dropping these low bits
    parameter int unsigned BYTE_SHIFT = $clog2(LANE_BYTES);

    //////////////////////////////////////////////////
    // Field widths shared by both ends of the link
    //////////////////////////////////////////////////

    parameter int unsigned SEQ_BITS = 8;    // Sequence number wraps modulo 256
    parameter int unsigned ID_BITS  = 8;    // Bus ids and FPGA ids have the same width

    // One beat on s_axi_tx_tdata
    typedef logic [LANE_BITS-1:0] lane_word_t;

    // The receiver expects these to count up by one per packet
    typedef logic [SEQ_BITS-1:0] seq_num_t;

endpackage

// File: src/aurora_tx_top.sv
`timescale 1ns/1ps

module aurora_tx_top #(
    parameter int unsigned                 PACKET_SIZE_BITS = 256,
    parameter packet_format_pkg::fpga_id_t ID_TARGET_FPGA   = 8'h01
) (
    input  logic                                 user_clk,
    input  logic                                 reset_TX_RX_Block,
    // FWFT packet FIFO
    input  logic                                 empty,
    output logic                                 rd_en,
    input  logic [PACKET_SIZE_BITS-1:0]          dout,
    // Aurora user port
    output logic [aurora_link_pkg::LANE_BITS-1:0] s_axi_tx_tdata,
    output logic                                 s_axi_tx_tvalid,
    output logic                                 s_axi_tx_tlast,
    input  logic                                 s_axi_tx_tready
);

    // One packet can wait here while the serializer sends the previous one
    packet_if #(
        .PACKET_SIZE_BITS (PACKET_SIZE_BITS)
    ) pkt_link ();

    // Pops, filters and stamps packets
    packet_fetch #(
        .PACKET_SIZE_BITS (PACKET_SIZE_BITS),
        .ID_TARGET_FPGA   (ID_TARGET_FPGA)
    ) packet_fetch_inst (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .rd_en             (rd_en),
        .dout              (dout),
        .pkt               (pkt_link.source)
    );

    // Sends header and payload beats under back-pressure
    beat_serializer #(
        .PACKET_SIZE_BITS (PACKET_SIZE_BITS)
    ) beat_serializer_inst (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .pkt               (pkt_link.sink),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast),
        .s_axi_tx_tready   (s_axi_tx_tready)
    );

endmodule

// File: src/beat_serializer.sv
`timescale 1ns/1ps

module beat_serializer #(
    parameter int unsigned PACKET_SIZE_BITS = 256
) (
    input  logic                        user_clk,
    input  logic                        reset_TX_RX_Block,
    packet_if.sink                      pkt,
    output aurora_link_pkg::lane_word_t s_axi_tx_tdata,
    output logic                        s_axi_tx_tvalid,
    output logic                        s_axi_tx_tlast,
    input  logic                        s_axi_tx_tready
);
    import aurora_link_pkg::*;
    import packet_format_pkg::*;

    localparam int unsigned HDR_LSB   = header_lsb(PACKET_SIZE_BITS);
    localparam int unsigned MAX_BEATS = PACKET_SIZE_BITS / LANE_BITS;
    localparam int unsigned PEND_BITS = $clog2(MAX_BEATS + 1);

    logic [PACKET_SIZE_BITS-1:0] shift_reg;    // Beats not yet handed to the output register
    logic [PEND_BITS-1:0]        pending;      // Beats left in shift_reg
    header_word_u                top_view;
    logic                        take_pkt;
    logic                        present;

    //////////////////////////////////////////////////
    // Beat selection
    //////////////////////////////////////////////////

    // The top lane of the register is always the next beat to go out
    assign top_view = shift_reg[HDR_LSB +: HEADER_BITS];

    assign take_pkt = pkt.valid && pkt.ready;

    // A new beat moves out when the output register is empty or its beat transfers
    assign present = (pending != '0) && (!s_axi_tx_tvalid || s_axi_tx_tready);

    //////////////////////////////////////////////////
    // Control and beat counting
    //////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            pending         <= '0;
            pkt.ready       <= 1'b1;   // Idle stage accepts a packet
            s_axi_tx_tvalid <= 1'b0;
            s_axi_tx_tlast  <= 1'b0;
        end else begin
            // Load only happens with pending at zero so it never meets present
            if (take_pkt) begin
                pending   <= PEND_BITS'(HEADER_BEATS + pkt.word_count);
                pkt.ready <= 1'b0;
            end else if (present) begin
                pending <= pending - 1'b1;
                // Last beat leaves the register so the next packet may load behind it
                if (pending == PEND_BITS'(1)) begin
                    pkt.ready <= 1'b1;
                end
            end

            // Output handshake
            if (present) begin
                s_axi_tx_tvalid <= 1'b1;
                s_axi_tx_tlast  <= (pending == PEND_BITS'(1));
            end else if (s_axi_tx_tvalid && s_axi_tx_tready) begin
                s_axi_tx_tvalid <= 1'b0;   // Nothing queued behind the beat that just went
                s_axi_tx_tlast  <= 1'b0;
            end
        end
    end

    // Data path
    always_ff @(posedge user_clk) begin
        if (take_pkt) begin
            shift_reg <= pkt.packet;
        end else if (present) begin
            shift_reg <= {shift_reg[PACKET_SIZE_BITS-LANE_BITS-1:0], {LANE_BITS{1'b0}}};
        end
        if (present) begin
            s_axi_tx_tdata <= top_view.beats[HEADER_BEATS-1];
        end
    end

    //////////////////////////////////////////////////
    // Stream protocol checks
    //////////////////////////////////////////////////

    // A waiting beat must not change until the Aurora core takes it
    a_hold_under_backpressure : assert property (
        @(posedge user_clk) disable iff (reset_TX_RX_Block)
        s_axi_tx_tvalid && !s_axi_tx_tready |=>
            s_axi_tx_tvalid && $stable(s_axi_tx_tdata) && $stable(s_axi_tx_tlast)
    ) else $error("Beat changed while waiting for tready");

    a_tlast_needs_tvalid : assert property (
        @(posedge user_clk) disable iff (reset_TX_RX_Block)
        s_axi_tx_tlast |-> s_axi_tx_tvalid
    ) else $error("tlast high without tvalid");

endmodule

// File: src/packet_fetch.sv
`timescale 1ns/1ps

module packet_fetch #(
    parameter int unsigned                 PACKET_SIZE_BITS = 256,
    parameter packet_format_pkg::fpga_id_t ID_TARGET_FPGA   = 8'h01
) (
    input  logic                        user_clk,
    input  logic                        reset_TX_RX_Block,
    input  logic                        empty,
    output logic                        rd_en,
    input  logic [PACKET_SIZE_BITS-1:0] dout,
    packet_if.source                    pkt
);
    import aurora_link_pkg::*;
    import packet_format_pkg::*;

    localparam int unsigned HDR_LSB   = header_lsb(PACKET_SIZE_BITS);
    // Most payload words that fit behind the header
    localparam int unsigned MAX_WORDS = (PACKET_SIZE_BITS - HEADER_BITS) / LANE_BITS;

    logic [PACKET_SIZE_BITS-1:0] pkt_buf;       // The single packet buffer
    logic                        loaded;        // Captured last edge and filter decision is due
    logic                        buf_free;
    logic                        drop;
    logic                        handoff;       // Packet moves to the serializer on this edge
    header_word_u                hdr;
    header_word_u                hdr_stamped;
    word_count_t                 word_count;
    seq_num_t                    seq_num;

    //////////////////////////////////////////////////
    // Header decode and filter
    //////////////////////////////////////////////////

    assign hdr        = pkt_buf[HDR_LSB +: HEADER_BITS];
    assign word_count = hdr.fields.valid_bytes[VALID_BYTES_BITS-1:BYTE_SHIFT];  // Bytes over four

    // A packet from the far end FPGA would loop forever in a broadcast
    assign drop = (hdr.fields.src_id == ID_TARGET_FPGA) ||
                  (word_count == '0) ||
                  (word_count > MAX_WORDS);

    // Sequence number goes where the bus id was
    always_comb begin
        hdr_stamped               = hdr;
        hdr_stamped.fields.bus_id = seq_num;
    end

    //////////////////////////////////////////////////
    // FIFO read and handoff control
    //////////////////////////////////////////////////

    // The buffer counts as busy from the read request until the handoff
    assign buf_free = !rd_en && !loaded && !pkt.valid;
    assign handoff  = pkt.valid && pkt.ready;

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            rd_en     <= 1'b0;
            loaded    <= 1'b0;
            pkt.valid <= 1'b0;
            seq_num   <= '0;
        end else begin
            rd_en  <= !empty && buf_free;   // One cycle pulse since rd_en itself marks the buffer busy
            loaded <= rd_en;                // FWFT data is captured on the rd_en edge

            // A dropped packet just lets loaded fall and the buffer is free again
            if (loaded && !drop) begin
                pkt.valid <= 1'b1;
            end else if (handoff) begin
                pkt.valid <= 1'b0;
            end

            // Only forwarded packets consume a sequence number
            if (handoff) begin
                seq_num <= seq_num + 1'b1;
            end
        end
    end

    // Payload buffer
    always_ff @(posedge user_clk) begin
        if (rd_en) begin
            pkt_buf <= dout;
        end else if (loaded && !drop) begin
            pkt_buf[HDR_LSB +: HEADER_BITS] <= hdr_stamped;   // Stamp in place while deciding
        end
    end

    assign pkt.packet     = pkt_buf;
    assign pkt.word_count = word_count;

    // The FIFO must hold a word whenever it is popped
    a_no_pop_when_empty : assert property (
        @(posedge user_clk) disable iff (reset_TX_RX_Block)
        rd_en |-> !empty
    ) else $error("rd_en high while the FIFO is empty");

endmodule

// File: src/packet_format_pkg.sv
package packet_format_pkg;

    //////////////////////////////////////////////////
    // Header layout of a FIFO packet
    //////////////////////////////////////////////////

    parameter int unsigned HEADER_BITS      = 64;
    parameter int unsigned HEADER_BEATS     = HEADER_BITS / aurora_link_pkg::LANE_BITS;
    parameter int unsigned RESERVED_BITS    = 32;
    parameter int unsigned VALID_BYTES_BITS = 16;

    // The valid byte count divided by four gives the payload word count
    parameter int unsigned WORD_COUNT_BITS  = VALID_BYTES_BITS - aurora_link_pkg::BYTE_SHIFT;

    typedef logic [aurora_link_pkg::ID_BITS-1:0] fpga_id_t;
    typedef logic [WORD_COUNT_BITS-1:0]          word_count_t;

    // Fields in transmit order with the bus id in the top byte
    typedef struct packed {
        logic [aurora_link_pkg::ID_BITS-1:0] bus_id;        // Replaced by the sequence number
        fpga_id_t                            src_id;        // FPGA that created the packet
        logic [RESERVED_BITS-1:0]            reserved;
        logic [VALID_BYTES_BITS-1:0]         valid_bytes;   // Payload size in bytes
    } header_fields_t;

    // The fetch stage decodes fields and the serializer sends two beats
    typedef union packed {
        header_fields_t                                fields;
        aurora_link_pkg::lane_word_t [HEADER_BEATS-1:0] beats;  // Index 1 goes out first
    } header_word_u;

    // The header sits at the top of the packet word and the payload follows below it
    function automatic int unsigned header_lsb(input int unsigned packet_bits);
        return packet_bits - HEADER_BITS;
    endfunction

endpackage

// File: src/packet_if.sv
`timescale 1ns/1ps

// Carries one filtered and stamped packet from the fetch stage to the serializer
interface packet_if #(
    parameter int unsigned PACKET_SIZE_BITS = 256
);
    import packet_format_pkg::*;

    logic                        valid;        // Packet and word_count hold while this waits
    logic                        ready;        // Serializer is idle and can load
    logic [PACKET_SIZE_BITS-1:0] packet;       // Whole packet with the sequence number in place
    word_count_t                 word_count;   // Payload words after the two header beats

    // Fetch side
    modport source (
        output valid,
        output packet,
        output word_count,
        input  ready
    );

    // Serializer side
    modport sink (
        input  valid,
        input  packet,
        input  word_count,
        output ready
    );

endinterface

// File: test/tb_packet_model.svh
`ifndef TB_PACKET_MODEL_SVH
`define TB_PACKET_MODEL_SVH

// Header bits from the top down are bus id, source id, 32 reserved bits, valid bytes
function automatic logic [PACKET_BITS-1:0] make_packet();
    logic [PACKET_BITS-1:0] p;
    int unsigned            pick;
    int unsigned            words;
    for (int i = 0; i < PACKET_BITS / 32; i++) begin
        p[i*32 +: 32] = $urandom;               // Random bus id, reserved bits and payload
    end
    pick = $urandom % 16;
    if (pick == 0) words = 0;                   // Empty packet, must be dropped
    else if (pick == 1) words = MAX_WORDS + 1 + ($urandom % 200);   // Over capacity
    else words = 1 + ($urandom % MAX_WORDS);
    // Roughly one packet in eight comes back from the far end FPGA
    p[PACKET_BITS-9 -: 8]  = (($urandom % 8) == 0) ? TARGET_ID : 8'($urandom);
    p[PACKET_BITS-49 -: 16] = 16'(words * 4);
    return p;
endfunction

// Payload words are the valid byte count over four
function automatic int unsigned packet_words(input logic [PACKET_BITS-1:0] p);
    return 32'(p[PACKET_BITS-49 -: 16]) >> 2;
endfunction

// Queues the beats a popped packet must produce, or counts it as dropped
function automatic void predict_beats(input logic [PACKET_BITS-1:0] p);
    int unsigned words;
    words = packet_words(p);
    if (p[PACKET_BITS-9 -: 8] == TARGET_ID || words == 0 || words > MAX_WORDS) begin
        dropped++;                              // No beats and no sequence number used
    end else begin
        exp_q.push_back({1'b0, exp_seq, p[PACKET_BITS-9 -: 24]});   // Sequence replaces bus id
        exp_q.push_back({1'b0, p[PACKET_BITS-33 -: 32]});
        for (int i = 0; i < words; i++) begin
            exp_q.push_back({i == words - 1, p[PACKET_BITS-65-32*i -: 32]});
        end
        exp_seq++;                              // Wraps from 255 to 0 by its width
        forwarded++;
    end
endfunction

`endif

// File: test/tb_aurora_tx_top.sv
`timescale 1ns/1ps

module tb_aurora_tx_top;
    import aurora_link_pkg::*;
    import packet_format_pkg::*;

    localparam int unsigned PACKET_BITS  = 256;
    localparam fpga_id_t    TARGET_ID    = 8'h5A;
    localparam int unsigned NUM_PACKETS  = 400;
    localparam int unsigned MAX_WORDS    = (PACKET_BITS - HEADER_BITS) / LANE_BITS;
    localparam int unsigned CYCLE_LIMIT  = NUM_PACKETS * (2 + MAX_WORDS) * 4 + 500;
    localparam int unsigned DRAIN_CYCLES = 20;      // Quiet cycles that catch stray beats

    logic                   user_clk = 1'b0;
    logic                   reset_TX_RX_Block;
    logic                   empty;
    logic                   rd_en;
    logic [PACKET_BITS-1:0] dout;
    lane_word_t             s_axi_tx_tdata;
    logic                   s_axi_tx_tvalid;
    logic                   s_axi_tx_tlast;
    logic                   s_axi_tx_tready;

    logic [PACKET_BITS-1:0] fifo_q[$];              // FIFO contents with the head at index 0
    logic [LANE_BITS:0]     exp_q[$];               // Expected beats as {tlast, tdata}
    logic [LANE_BITS:0]     exp_beat;
    logic [LANE_BITS:0]     held_beat;
    logic                   holding = 1'b0;         // A beat waited for tready last cycle
    logic                   running = 1'b0;
    seq_num_t               exp_seq = '0;
    int unsigned            pops = 0;
    int unsigned            forwarded = 0;
    int unsigned            dropped = 0;
    int unsigned            checks = 0;
    int unsigned            cycles = 0;
    int unsigned            idle_cycles = 0;
    int unsigned            reset_errors = 0;
    int unsigned            stream_errors = 0;
    int unsigned            fifo_errors = 0;
    int unsigned            seq_errors = 0;

    `include "tb_packet_model.svh"

    always #10 user_clk = ~user_clk;

    aurora_tx_top #(
        .PACKET_SIZE_BITS (PACKET_BITS),
        .ID_TARGET_FPGA   (TARGET_ID)
    ) aurora_tx_top_inst (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .rd_en             (rd_en),
        .dout              (dout),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast),
        .s_axi_tx_tready   (s_axi_tx_tready)
    );

    //////////////////////////////////////////////////
    // Monitor at the falling edge where all signals are settled
    //////////////////////////////////////////////////

    always @(negedge user_clk) begin
        if (running) begin
            checks++;
            assert (!(rd_en && empty)) else begin
                $display("** Error at time %0t: rd_en high while empty is high", $time);
                fifo_errors++;
            end
            if (rd_en && !empty && fifo_q.size() > 0) begin
                predict_beats(fifo_q.pop_front());  // Pop happens on the coming rising edge
                pops++;
            end
            if (holding) begin
                checks++;
                assert (s_axi_tx_tvalid && {s_axi_tx_tlast, s_axi_tx_tdata} == held_beat) else begin
                    $display("** Error at time %0t: waiting beat %h changed", $time, held_beat);
                    stream_errors++;
                end
            end
            holding   = s_axi_tx_tvalid && !s_axi_tx_tready;
            held_beat = {s_axi_tx_tlast, s_axi_tx_tdata};
            if (s_axi_tx_tvalid && s_axi_tx_tready) begin
                if (exp_q.size() == 0) begin
                    $display("A beat was sent when no packet was left to send");
                    stream_errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    checks++;
                    assert ({s_axi_tx_tlast, s_axi_tx_tdata} == exp_beat) else begin
                        $display("** Error at time %0t: beat got %b/%h expected %b/%h", $time,
                                 s_axi_tx_tlast, s_axi_tx_tdata, exp_beat[LANE_BITS],
                                 exp_beat[LANE_BITS-1:0]);
                        stream_errors++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus and end of run
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(93));
        reset_TX_RX_Block = 1'b1;
        empty             = 1'b1;
        dout              = '0;
        s_axi_tx_tready   = 1'b0;
        for (int n = 0; n < NUM_PACKETS; n++) begin
            fifo_q.push_back(make_packet());
        end
        repeat (3) @(posedge user_clk);
        #1;
        reset_TX_RX_Block = 1'b0;
        checks++;
        assert (!rd_en && !s_axi_tx_tvalid && !s_axi_tx_tlast) else begin
            $display("** Error at time %0t: outputs not low after reset", $time);
            reset_errors++;
        end
        $display("reset_state   : %s", (reset_errors == 0) ? "PASS" : "FAIL");
        running = 1'b1;
        while (idle_cycles < DRAIN_CYCLES && cycles < CYCLE_LIMIT) begin
            @(posedge user_clk);
            #1;
            cycles++;
            // A pending pop keeps the head in place, otherwise gaps come at random
            if (fifo_q.size() > 0 && (rd_en || ($urandom % 4) != 0)) begin
                empty = 1'b0;
                dout  = fifo_q[0];
            end else begin
                empty = 1'b1;
            end
            s_axi_tx_tready = ($urandom % 3) != 0;
            // The run ends once the DUT goes quiet even with packets left in the FIFO
            if (exp_q.size() == 0 && !s_axi_tx_tvalid && !rd_en) idle_cycles++;
            else idle_cycles = 0;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d packets unread and %0d beats not sent",
                     cycles, fifo_q.size(), exp_q.size());
            $display("Test failed");
        end else begin
            checks++;
            assert (forwarded > (1 << SEQ_BITS)) else begin
                $display("Only %0d packets were forwarded so the sequence never wrapped", forwarded);
                seq_errors++;
            end
            checks++;
            assert (pops == NUM_PACKETS) else begin
                $display("** Error at time %0t: %0d packets popped of %0d", $time, pops, NUM_PACKETS);
                fifo_errors++;
            end
            $display("packet_stream : %s (%0d forwarded, %0d dropped)",
                     (stream_errors == 0) ? "PASS" : "FAIL", forwarded, dropped);
            $display("sequence_wrap : %s", (seq_errors == 0) ? "PASS" : "FAIL");
            $display("fifo_pops     : %s (%0d popped)", (fifo_errors == 0) ? "PASS" : "FAIL", pops);
            $display("Checks: %0d, errors: %0d", checks,
                     reset_errors + stream_errors + fifo_errors + seq_errors);
            if (reset_errors + stream_errors + fifo_errors + seq_errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule
